// ==== logic/raster_pkg.sv ====
package raster_pkg;

	// ------------------------------------------------------------------------
	// screen side: columns, lines, colours
	// ------------------------------------------------------------------------

	typedef logic [8:0] x_t;		// pixel column, also line buffer address
	typedef logic [8:0] line_t;		// raster line number
	typedef logic [5:0] color_t;	// output colour

	// palette entry, also the line buffer word
	// bit 6 set means transparent, bits 5:0 the colour
	typedef logic [6:0] pal_entry_t;
	typedef logic [7:0] pal_addr_t;	// bank joined to the pixel index

	localparam int TRANSP_BIT = 6;

	// what a cleared buffer slot holds
	localparam pal_entry_t BLANK_ENTRY = 7'b100_0000;

	// read-out step, one pixel every four clocks
	localparam int CLOCKS_PER_PIXEL = 4;

endpackage

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

	// ------------------------------------------------------------------------
	// shared word memory and sprite descriptors
	// ------------------------------------------------------------------------

	typedef logic [20:0] mem_addr_t;	// word address
	typedef logic [15:0] mem_word_t;
	typedef logic [7:0]  desc_byte_t;

	// colour mode, low bits of descriptor byte 4
	typedef enum logic [1:0] {
		CRES_OFF    = 2'd0,
		CRES_4C     = 2'd1,	// 8 px per word
		CRES_16C    = 2'd2,	// 4 px per word
		CRES_DIRECT = 2'd3	// 2 px per word, no palette
	} cres_e;

	// sprite engine FSM
	typedef enum logic [3:0] {
		RS_CTRL, RS_Y_LO, RS_Y_HI, RS_X_HI, RS_X_LO,
		RS_A_LO, RS_A_MID, RS_A_HI, RS_FETCH, RS_UNPACK,
		RS_NEXT, RS_DONE
	} render_state_e;

	typedef enum logic {
		OWN_ENGINE = 1'b0,
		OWN_HOST   = 1'b1
	} arb_owner_e;

	// byte offsets within one 8 byte descriptor
	localparam logic [2:0] DESC_X_LO     = 3'd0;
	localparam logic [2:0] DESC_X_HI     = 3'd1;	// x8, width in words
	localparam logic [2:0] DESC_Y_LO     = 3'd2;
	localparam logic [2:0] DESC_Y_HI     = 3'd3;	// y8, vflip, height / 8
	localparam logic [2:0] DESC_CTRL     = 3'd4;	// bank, cres
	localparam logic [2:0] DESC_ADDR_LO  = 3'd5;
	localparam logic [2:0] DESC_ADDR_MID = 3'd6;
	localparam logic [2:0] DESC_ADDR_HI  = 3'd7;

endpackage

// ==== logic/line_buffer_ram.sv ====
`timescale 1ns/100ps

module line_buffer_ram (
	input  logic                   clk,
	input  logic                   wr_en,
	input  raster_pkg::x_t         wr_addr,
	input  raster_pkg::pal_entry_t wr_data,
	input  raster_pkg::x_t         rd_addr,
	output raster_pkg::pal_entry_t rd_data
);

	localparam int DEPTH = 2 ** $bits(raster_pkg::x_t);	// 512 slots

	raster_pkg::pal_entry_t mem [0:DEPTH-1];

	always_ff @(posedge clk)
		if (wr_en)
			mem[wr_addr] <= wr_data;

	assign rd_data = mem[rd_addr];	// async read

endmodule

// ==== logic/line_store.sv ====
`timescale 1ns/100ps

module line_store #(
	parameter int LINE_PIXELS = 360
) (
	input  logic                   clk,
	input  logic                   line_start,
	input  logic                   pre_vline,
	input  logic                   wr_en,
	input  raster_pkg::x_t         wr_x,
	input  raster_pkg::pal_entry_t wr_color,
	output raster_pkg::line_t      vline,
	output raster_pkg::color_t     pixel,
	output logic                   pixel_opaque
);

	localparam int PH_W = $clog2(raster_pkg::CLOCKS_PER_PIXEL);
	localparam logic [PH_W-1:0] PH_READ  = PH_W'(0);
	localparam logic [PH_W-1:0] PH_CLEAR = PH_W'(1);
	localparam logic [PH_W-1:0] PH_ADV   = PH_W'(2);	// phase 3 idles
	localparam logic [PH_W-1:0] PH_LAST  = PH_W'(raster_pkg::CLOCKS_PER_PIXEL - 1);
	localparam raster_pkg::x_t LAST_X = raster_pkg::x_t'(LINE_PIXELS - 1);

	logic                   disp_sel;	// buffer being shown, the other one renders
	logic [PH_W-1:0]        phase;
	raster_pkg::x_t         rd_x;
	logic                   first_clr;
	logic                   disp_clr;
	logic                   ren_we;
	raster_pkg::x_t         ren_wa;
	raster_pkg::pal_entry_t ren_wd;
	raster_pkg::pal_entry_t rd0;
	raster_pkg::pal_entry_t rd1;
	raster_pkg::pal_entry_t rd_cur;

	// line counter, synchronous strobe
	always_ff @(posedge clk)
		if (line_start)
		begin
			vline    <= pre_vline ? '0 : vline + 1'b1;
			disp_sel <= ~disp_sel;	// swap every line
		end

	// ------------------------------------------------------------------------
	// read-out sequencer: read, clear, advance, idle
	// ------------------------------------------------------------------------
	// starts in clear with rd_x at all ones, so slot 0 is read on the 4th edge
	always_ff @(posedge clk, posedge line_start)
		if (line_start)
		begin
			phase        <= PH_CLEAR;
			rd_x         <= '1;
			pixel_opaque <= 1'b0;
		end
		else
		begin
			phase <= (phase == PH_LAST) ? PH_READ : phase + 1'b1;
			if (phase == PH_READ)
				pixel_opaque <= ~rd_cur[raster_pkg::TRANSP_BIT];
			if (phase == PH_ADV && rd_x != LAST_X)
				rd_x <= rd_x + 1'b1;	// hold on the last column
		end

	always_ff @(posedge clk)
		if (phase == PH_READ)
			pixel <= rd_cur[5:0];

	// last slot of the old display buffer is read as line_start hits,
	// so it gets wiped here on the first step of the new line instead
	assign first_clr = (phase == PH_CLEAR) && (rd_x == '1) && !line_start;
	assign disp_clr  = (phase == PH_CLEAR) && (rd_x != '1);

	// render side port
	assign ren_we = wr_en | first_clr;
	assign ren_wa = first_clr ? LAST_X : wr_x;
	assign ren_wd = first_clr ? raster_pkg::BLANK_ENTRY : wr_color;

	assign rd_cur = disp_sel ? rd1 : rd0;

	line_buffer_ram i_buf0 (
		.clk     (clk),
		.wr_en   (disp_sel ? ren_we : disp_clr),
		.wr_addr (disp_sel ? ren_wa : rd_x),
		.wr_data (disp_sel ? ren_wd : raster_pkg::BLANK_ENTRY),
		.rd_addr (rd_x),
		.rd_data (rd0)
	);

	line_buffer_ram i_buf1 (
		.clk     (clk),
		.wr_en   (disp_sel ? disp_clr : ren_we),
		.wr_addr (disp_sel ? rd_x : ren_wa),
		.wr_data (disp_sel ? raster_pkg::BLANK_ENTRY : ren_wd),
		.rd_addr (rd_x),
		.rd_data (rd1)
	);

endmodule

// ==== logic/sprite_engine.sv ====
`timescale 1ns/100ps

module sprite_engine #(
	parameter  int SPRITE_COUNT = 64,
	localparam int NUM_W        = $clog2(SPRITE_COUNT),
	localparam int DESC_AW      = NUM_W + 3
) (
	input  logic                   clk,
	input  logic                   line_start,
	input  raster_pkg::line_t      vline,
	input  fetch_pkg::desc_byte_t  desc_data,
	input  raster_pkg::pal_entry_t pal_data,
	input  logic                   spr_strobe,
	input  fetch_pkg::mem_word_t   mem_data,
	output logic [DESC_AW-1:0]     desc_addr,
	output raster_pkg::pal_addr_t  pal_addr,
	output logic                   spr_req,
	output fetch_pkg::mem_addr_t   spr_addr,
	output logic                   wr_en,
	output raster_pkg::x_t         wr_x,
	output raster_pkg::pal_entry_t wr_color,
	output logic                   render_busy
);

	fetch_pkg::render_state_e state;
	logic [NUM_W-1:0]         num;		// sprite being walked
	fetch_pkg::cres_e         cres;
	logic [5:0]               bank;
	fetch_pkg::desc_byte_t    y_lo;
	fetch_pkg::desc_byte_t    base_lo;
	fetch_pkg::desc_byte_t    base_mid;
	logic [8:0]               row;		// line within the sprite
	logic [6:0]               width;
	logic [6:0]               words_left;
	logic [3:0]               pix_left;
	logic [3:0]               word_pixels;
	raster_pkg::x_t           x_pos;
	raster_pkg::x_t           pend_x;
	fetch_pkg::mem_word_t     sh;		// word being unpacked, msb first
	logic                     pend;		// pixel waiting on the palette
	raster_pkg::pal_entry_t   pend_entry;
	raster_pkg::pal_entry_t   entry;
	logic [9:0]               vl;
	logic [9:0]               y_top;
	logic [9:0]               y_end;
	logic [9:0]               row_calc;
	logic [15:0]              row_ofs;
	logic                     vis;
	logic                     last_sprite;
	logic                     last_pix;

	// y check, 10 bits so y + height cannot wrap
	assign vl       = {1'b0, vline};
	assign y_top    = {1'b0, desc_data[7], y_lo};	// byte 3 on the bus
	assign y_end    = y_top + {1'b0, desc_data[5:0], 3'b000};
	assign vis      = (vl >= y_top) && (vl < y_end);
	assign row_calc = desc_data[6] ? (y_end - vl - 10'd1) : (vl - y_top);	// vflip
	assign row_ofs  = row * width;

	assign last_sprite = (num == NUM_W'(SPRITE_COUNT - 1));
	assign last_pix    = (pix_left == 4'd1);
	assign entry       = (cres == fetch_pkg::CRES_DIRECT) ? pend_entry : pal_data;
	assign render_busy = (state != fetch_pkg::RS_DONE) || pend || wr_en;

	always_comb
		case (cres)
			fetch_pkg::CRES_4C:  word_pixels = 4'd8;
			fetch_pkg::CRES_16C: word_pixels = 4'd4;
			default:             word_pixels = 4'd2;
		endcase

	// ------------------------------------------------------------------------
	// control: descriptor walk and fetch sequencing
	// ------------------------------------------------------------------------
	always_ff @(posedge clk, posedge line_start)
		if (line_start)
		begin
			state      <= fetch_pkg::RS_CTRL;
			num        <= '0;
			desc_addr  <= {{NUM_W{1'b0}}, fetch_pkg::DESC_CTRL};
			spr_req    <= 1'b0;
			words_left <= '0;
			pix_left   <= '0;
			pend       <= 1'b0;
			wr_en      <= 1'b0;
		end
		else
		begin
			pend  <= (state == fetch_pkg::RS_UNPACK);
			wr_en <= pend && !entry[raster_pkg::TRANSP_BIT];	// opaque only
			case (state)
				fetch_pkg::RS_CTRL:
					if (desc_data[1:0] == fetch_pkg::CRES_OFF)
						state <= fetch_pkg::RS_NEXT;
					else
					begin
						desc_addr <= {num, fetch_pkg::DESC_Y_LO};
						state     <= fetch_pkg::RS_Y_LO;
					end
				fetch_pkg::RS_Y_LO:
				begin
					desc_addr <= {num, fetch_pkg::DESC_Y_HI};
					state     <= fetch_pkg::RS_Y_HI;
				end
				fetch_pkg::RS_Y_HI:
					if (vis)
					begin
						desc_addr <= {num, fetch_pkg::DESC_X_HI};
						state     <= fetch_pkg::RS_X_HI;
					end
					else
						state <= fetch_pkg::RS_NEXT;	// not on this line
				fetch_pkg::RS_X_HI:
					if (desc_data[6:0] == 7'd0)
						state <= fetch_pkg::RS_NEXT;	// zero width
					else
					begin
						words_left <= desc_data[6:0];
						desc_addr  <= {num, fetch_pkg::DESC_X_LO};
						state      <= fetch_pkg::RS_X_LO;
					end
				fetch_pkg::RS_X_LO:
				begin
					desc_addr <= {num, fetch_pkg::DESC_ADDR_LO};
					state     <= fetch_pkg::RS_A_LO;
				end
				fetch_pkg::RS_A_LO:
				begin
					desc_addr <= {num, fetch_pkg::DESC_ADDR_MID};
					state     <= fetch_pkg::RS_A_MID;
				end
				fetch_pkg::RS_A_MID:
				begin
					desc_addr <= {num, fetch_pkg::DESC_ADDR_HI};
					state     <= fetch_pkg::RS_A_HI;
				end
				fetch_pkg::RS_A_HI:
				begin
					spr_req <= 1'b1;	// row address lands this edge
					state   <= fetch_pkg::RS_FETCH;
				end
				fetch_pkg::RS_FETCH:
					if (spr_strobe)
					begin
						spr_req    <= 1'b0;
						words_left <= words_left - 1'b1;
						pix_left   <= word_pixels;
						state      <= fetch_pkg::RS_UNPACK;
					end
				fetch_pkg::RS_UNPACK:
				begin
					pix_left <= pix_left - 1'b1;
					if (last_pix)
					begin
						if (words_left == 7'd0)
							state <= fetch_pkg::RS_NEXT;
						else
						begin
							spr_req <= 1'b1;	// next word of the row
							state   <= fetch_pkg::RS_FETCH;
						end
					end
				end
				fetch_pkg::RS_NEXT:
					if (last_sprite)
						state <= fetch_pkg::RS_DONE;
					else
					begin
						num       <= num + 1'b1;
						desc_addr <= {num + 1'b1, fetch_pkg::DESC_CTRL};
						state     <= fetch_pkg::RS_CTRL;
					end
				default: ;	// done, wait for line_start
			endcase
		end

	// datapath: descriptor fields, row address, unpack
	always_ff @(posedge clk)
	begin
		wr_x     <= pend_x;
		wr_color <= entry;
		case (state)
			fetch_pkg::RS_CTRL:
			begin
				cres <= fetch_pkg::cres_e'(desc_data[1:0]);
				bank <= desc_data[7:2];
			end
			fetch_pkg::RS_Y_LO:  y_lo <= desc_data;
			fetch_pkg::RS_Y_HI:  row  <= row_calc[8:0];
			fetch_pkg::RS_X_HI:
			begin
				width    <= desc_data[6:0];
				x_pos[8] <= desc_data[7];
			end
			fetch_pkg::RS_X_LO:  x_pos[7:0] <= desc_data;
			fetch_pkg::RS_A_LO:  base_lo    <= desc_data;
			fetch_pkg::RS_A_MID: base_mid   <= desc_data;
			fetch_pkg::RS_A_HI:	// base + row * width
				spr_addr <= {desc_data[4:0], base_mid, base_lo} + {5'b0, row_ofs};
			fetch_pkg::RS_FETCH:
				if (spr_strobe)
				begin
					sh       <= mem_data;
					spr_addr <= spr_addr + 1'b1;
				end
			fetch_pkg::RS_UNPACK:
			begin
				pend_x <= x_pos;
				x_pos  <= x_pos + 1'b1;
				case (cres)
					fetch_pkg::CRES_4C:
					begin
						pal_addr <= {bank, sh[15:14]};
						sh       <= sh << 2;
					end
					fetch_pkg::CRES_16C:
					begin
						pal_addr <= {bank[5:2], sh[15:12]};	// index covers bank bits 1:0
						sh       <= sh << 4;
					end
					default:
					begin
						pend_entry <= {sh[14], sh[13:8]};	// direct byte
						sh         <= sh << 8;
					end
				endcase
			end
			default: ;
		endcase
	end

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter (
	input  logic                 clk,
	input  logic                 line_start,
	input  logic                 spr_req,
	input  fetch_pkg::mem_addr_t spr_addr,
	input  logic                 host_req,
	input  fetch_pkg::mem_addr_t host_addr,
	input  logic                 mem_strobe,
	output logic                 mem_req,
	output fetch_pkg::mem_addr_t mem_addr,
	output logic                 spr_strobe,
	output logic                 host_strobe
);

	fetch_pkg::arb_owner_e owner;
	fetch_pkg::arb_owner_e last;	// served most recently
	fetch_pkg::arb_owner_e other;
	logic                  active;	// owner granted, req passed to memory
	logic                  own_req;
	logic                  oth_req;
	logic                  own_eng;

	assign own_eng = (owner == fetch_pkg::OWN_ENGINE);
	assign other   = own_eng ? fetch_pkg::OWN_HOST : fetch_pkg::OWN_ENGINE;
	assign own_req = own_eng ? spr_req : host_req;
	assign oth_req = own_eng ? host_req : spr_req;

	assign mem_req     = active & own_req;
	assign mem_addr    = own_eng ? spr_addr : host_addr;
	assign spr_strobe  = mem_strobe & active & own_eng;	// owner only
	assign host_strobe = mem_strobe & active & ~own_eng;

	always_ff @(posedge clk, posedge line_start)
		if (line_start)
		begin
			owner  <= fetch_pkg::OWN_ENGINE;
			last   <= fetch_pkg::OWN_HOST;
			active <= 1'b0;
		end
		else if (!active)
		begin
			// idle grant, the one not served last wins a tie
			if (spr_req && host_req)
				owner <= (last == fetch_pkg::OWN_ENGINE) ? fetch_pkg::OWN_HOST
				                                         : fetch_pkg::OWN_ENGINE;
			else if (spr_req)
				owner <= fetch_pkg::OWN_ENGINE;
			else if (host_req)
				owner <= fetch_pkg::OWN_HOST;
			active <= spr_req | host_req;
		end
		else if (mem_strobe)
		begin
			last <= owner;
			if (oth_req)
				owner <= other;		// hand over, stays active
			else
				active <= 1'b0;
		end
		else if (!own_req)
			active <= 1'b0;		// request dropped, transfer abandoned

endmodule

// ==== logic/sprite_unit.sv ====
`timescale 1ns/100ps

module sprite_unit #(
	parameter  int SPRITE_COUNT = 64,
	parameter  int LINE_PIXELS  = 360,
	localparam int DESC_AW      = $clog2(SPRITE_COUNT) + 3
) (
	input  logic                   clk,
	input  logic                   line_start,
	input  logic                   pre_vline,
	input  fetch_pkg::desc_byte_t  desc_data,
	input  raster_pkg::pal_entry_t pal_data,
	input  logic                   mem_strobe,
	input  fetch_pkg::mem_word_t   mem_data,
	input  logic                   host_req,
	input  fetch_pkg::mem_addr_t   host_addr,
	output logic [DESC_AW-1:0]     desc_addr,
	output raster_pkg::pal_addr_t  pal_addr,
	output logic                   mem_req,
	output fetch_pkg::mem_addr_t   mem_addr,
	output logic                   host_strobe,
	output raster_pkg::color_t     pixel,
	output logic                   pixel_opaque,
	output logic                   render_busy
);

	raster_pkg::line_t      vline;
	logic                   spr_req;
	fetch_pkg::mem_addr_t   spr_addr;
	logic                   spr_strobe;
	logic                   wr_en;
	raster_pkg::x_t         wr_x;
	raster_pkg::pal_entry_t wr_color;

	// ------------------------------------------------------------------------
	// line buffers and read-out
	// ------------------------------------------------------------------------
	line_store #(
		.LINE_PIXELS (LINE_PIXELS)
	) i_line_store (
		.clk          (clk),
		.line_start   (line_start),
		.pre_vline    (pre_vline),
		.wr_en        (wr_en),
		.wr_x         (wr_x),
		.wr_color     (wr_color),
		.vline        (vline),
		.pixel        (pixel),
		.pixel_opaque (pixel_opaque)
	);

	sprite_engine #(
		.SPRITE_COUNT (SPRITE_COUNT)
	) i_sprite_engine (
		.clk         (clk),
		.line_start  (line_start),
		.vline       (vline),
		.desc_data   (desc_data),
		.pal_data    (pal_data),
		.spr_strobe  (spr_strobe),
		.mem_data    (mem_data),	// shared with the host
		.desc_addr   (desc_addr),
		.pal_addr    (pal_addr),
		.spr_req     (spr_req),
		.spr_addr    (spr_addr),
		.wr_en       (wr_en),
		.wr_x        (wr_x),
		.wr_color    (wr_color),
		.render_busy (render_busy)
	);

	// engine vs host on the word memory
	mem_arbiter i_mem_arbiter (
		.clk         (clk),
		.line_start  (line_start),
		.spr_req     (spr_req),
		.spr_addr    (spr_addr),
		.host_req    (host_req),
		.host_addr   (host_addr),
		.mem_strobe  (mem_strobe),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.spr_strobe  (spr_strobe),
		.host_strobe (host_strobe)
	);

endmodule

// ==== dv/sprite_mem_model.sv ====
`timescale 1ns/100ps

module sprite_mem_model #(
	parameter int DESC_AW = 9
) (
	input  logic                   clk,
	input  logic                   mem_req,
	input  fetch_pkg::mem_addr_t   mem_addr,
	output logic                   mem_strobe,
	output fetch_pkg::mem_word_t   mem_data,
	input  logic [DESC_AW-1:0]     desc_addr,
	output fetch_pkg::desc_byte_t  desc_data,
	input  raster_pkg::pal_addr_t  pal_addr,
	output raster_pkg::pal_entry_t pal_data
);

	// arrays are filled by the testbench through hierarchical names
	fetch_pkg::mem_word_t   words [0:4095];	// low 12 address bits decode
	fetch_pkg::desc_byte_t  desc [0:2**DESC_AW-1];
	raster_pkg::pal_entry_t pal [0:255];

	integer     seed = 32'h8d085bd2;
	integer     rnd;
	logic [2:0] wait_cnt;	// 0 means no transfer in flight

	assign desc_data = desc[desc_addr];	// async reads
	assign pal_data  = pal[pal_addr];

	initial
	begin
		mem_strobe = 1'b0;
		mem_data   = '0;
		wait_cnt   = '0;
	end

	// ------------------------------------------------------------------------
	// word port: 1 to 4 cycles of latency per transfer
	// ------------------------------------------------------------------------
	always @(posedge clk)
	begin
		mem_strobe <= 1'b0;
		if (!mem_req || mem_strobe)
			wait_cnt <= '0;	// dropped req abandons, strobe ends a transfer
		else if (wait_cnt == 3'd0)
		begin
			rnd = $random(seed);
			wait_cnt <= {1'b0, rnd[1:0]} + 3'd1;
		end
		else if (wait_cnt == 3'd1)
		begin
			mem_strobe <= 1'b1;
			mem_data   <= words[mem_addr[11:0]];
			wait_cnt   <= '0;
		end
		else
			wait_cnt <= wait_cnt - 3'd1;
	end

endmodule

// ==== dv/sprite_unit_tb.sv ====
`timescale 1ns/100ps

module sprite_unit_tb;

	localparam int SPRITE_COUNT = 64;
	localparam int LINE_PIXELS  = 360;
	localparam int LINE_CLOCKS  = 1440;
	localparam int DESC_AW      = $clog2(SPRITE_COUNT) + 3;
	localparam int FRAMES       = 4;
	localparam int ROWS         = 10;
	localparam int TABLE_LINES  = 3 + 4 + 12 + 3;	// sum of frame_lines
	localparam int CYCLE_LIMIT  = (TABLE_LINES + 1) * LINE_CLOCKS + 2000;
	localparam int HOST_LIMIT   = 40;

	// one sprite descriptor of the scenario table
	typedef struct packed {
		int frame;
		int num;
		int x;
		int y;
		int h;
		int flip;
		int w;
		int bank;
		int cres;
		int base;
	} spr_row_t;

	logic                   clk;
	logic                   line_start;
	logic                   pre_vline;
	logic                   host_req;
	fetch_pkg::mem_addr_t   host_addr;
	logic [DESC_AW-1:0]     desc_addr;
	fetch_pkg::desc_byte_t  desc_data;
	raster_pkg::pal_addr_t  pal_addr;
	raster_pkg::pal_entry_t pal_data;
	logic                   mem_req;
	fetch_pkg::mem_addr_t   mem_addr;
	logic                   mem_strobe;
	fetch_pkg::mem_word_t   mem_data;
	logic                   host_strobe;
	raster_pkg::color_t     pixel;
	logic                   pixel_opaque;
	logic                   render_busy;

	spr_row_t               spr_tab [0:ROWS-1];
	int                     frame_lines [0:FRAMES-1];
	int                     frame_hosts [0:FRAMES-1];
	logic [15:0]            frame_salt [0:FRAMES-1];
	raster_pkg::pal_entry_t exp_next [0:511];	// line being rendered
	raster_pkg::pal_entry_t exp_cur [0:511];	// line being shown
	raster_pkg::line_t      tb_line;
	int                     cur_frame;
	int                     lines_run;
	int                     error_count = 0;
	int                     cycle_count = 0;

	sprite_unit #(
		.SPRITE_COUNT (SPRITE_COUNT),
		.LINE_PIXELS  (LINE_PIXELS)
	) i_dut (
		.clk          (clk),
		.line_start   (line_start),
		.pre_vline    (pre_vline),
		.desc_data    (desc_data),
		.pal_data     (pal_data),
		.mem_strobe   (mem_strobe),
		.mem_data     (mem_data),
		.host_req     (host_req),
		.host_addr    (host_addr),
		.desc_addr    (desc_addr),
		.pal_addr     (pal_addr),
		.mem_req      (mem_req),
		.mem_addr     (mem_addr),
		.host_strobe  (host_strobe),
		.pixel        (pixel),
		.pixel_opaque (pixel_opaque),
		.render_busy  (render_busy)
	);

	sprite_mem_model #(
		.DESC_AW (DESC_AW)
	) i_mem (
		.clk        (clk),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_strobe (mem_strobe),
		.mem_data   (mem_data),
		.desc_addr  (desc_addr),
		.desc_data  (desc_data),
		.pal_addr   (pal_addr),
		.pal_data   (pal_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("run exceeded %0d clock cycles without finishing", CYCLE_LIMIT);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	// ------------------------------------------------------------------------
	// scenario table: frame, sprite, x, y, h, flip, w, bank, cres, base
	// ------------------------------------------------------------------------
	task automatic fill_table();
		frame_lines = '{3, 4, 12, 3};	// frame 0 has every sprite off
		frame_hosts = '{0, 0, 0, 4};	// host reads per line
		frame_salt  = '{16'h0000, 16'h1357, 16'h2a4c, 16'h5e01};
		spr_tab[0] = '{1, 3, 20, 1, 1, 0, 2, 5, 1, 'h100};
		spr_tab[1] = '{1, 10, 30, 0, 1, 0, 3, 'h22, 2, 'h200};	// overlaps sprite 3
		spr_tab[2] = '{1, 40, 100, 2, 1, 0, 4, 0, 3, 'h300};
		spr_tab[3] = '{2, 5, 300, 3, 1, 1, 1, 9, 1, 'h080};	// x bit 8, flipped
		spr_tab[4] = '{2, 6, 10, 5, 2, 0, 2, 'h31, 2, 'h400};
		spr_tab[5] = '{2, 63, 150, 0, 1, 1, 3, 0, 3, 'h500};
		spr_tab[6] = '{3, 0, 20, 0, 1, 0, 8, 'h12, 1, 'h600};
		spr_tab[7] = '{3, 1, 40, 1, 1, 0, 4, 'h3c, 2, 'h700};
		spr_tab[8] = '{3, 2, 50, 0, 2, 1, 6, 0, 3, 'h800};
		spr_tab[9] = '{3, 60, 60, 0, 1, 0, 2, 7, 1, 'h900};
	endtask

	function automatic fetch_pkg::mem_word_t fill_word(input int i, input logic [15:0] salt);
		logic [15:0] a;
		a = i[15:0];
		return (a * 16'h2f1b) ^ {a[3:0], a[11:0]} ^ salt;
	endfunction

	task automatic load_frame(input int f);
		int a;
		for (int i = 0; i < 4096; i++)
			i_mem.words[i] = fill_word(i, frame_salt[f]);
		for (int i = 0; i < 8 * SPRITE_COUNT; i++)
			i_mem.desc[i] = 8'h00;	// mode off everywhere
		for (int r = 0; r < ROWS; r++)
			if (spr_tab[r].frame == f)
			begin
				a = spr_tab[r].num * 8;
				i_mem.desc[a]     = spr_tab[r].x[7:0];
				i_mem.desc[a + 1] = {spr_tab[r].x[8], spr_tab[r].w[6:0]};
				i_mem.desc[a + 2] = spr_tab[r].y[7:0];
				i_mem.desc[a + 3] = {spr_tab[r].y[8], spr_tab[r].flip[0], spr_tab[r].h[5:0]};
				i_mem.desc[a + 4] = {spr_tab[r].bank[5:0], spr_tab[r].cres[1:0]};
				i_mem.desc[a + 5] = spr_tab[r].base[7:0];
				i_mem.desc[a + 6] = spr_tab[r].base[15:8];
				i_mem.desc[a + 7] = {3'b000, spr_tab[r].base[20:16]};
			end
	endtask

	// reference renderer, descriptor order so later sprites win
	task automatic render_ref(input raster_pkg::line_t line);
		fetch_pkg::desc_byte_t  b [0:7];
		int                     ln, y, h, x, w, row, cres, addr, bpp;
		logic [5:0]             bank;
		logic [15:0]            word;
		logic [15:0]            fld;
		raster_pkg::pal_entry_t e;
		ln = line;
		for (int k = 0; k < 512; k++)
			exp_next[k] = 7'h40;	// transparent
		for (int s = 0; s < SPRITE_COUNT; s++)
		begin
			for (int j = 0; j < 8; j++)
				b[j] = i_mem.desc[s * 8 + j];
			cres = b[4][1:0];
			bank = b[4][7:2];
			y    = {b[3][7], b[2]};
			h    = b[3][5:0];
			w    = b[1][6:0];
			x    = {b[1][7], b[0]};
			bpp  = (cres == 1) ? 2 : (cres == 2) ? 4 : 8;
			if (cres != 0 && w != 0 && ln >= y && ln < y + 8 * h)
			begin
				row  = b[3][6] ? (y + 8 * h - 1 - ln) : (ln - y);
				addr = {b[7][4:0], b[6], b[5]} + row * w;
				for (int n = 0; n < w; n++)
				begin
					word = i_mem.words[(addr + n) % 4096];
					for (int p = 0; p < 16 / bpp; p++)
					begin
						fld = word >> (16 - bpp * (p + 1));	// msb first
						case (cres)
							1:       e = i_mem.pal[{bank, fld[1:0]}];
							2:       e = i_mem.pal[{bank[5:2], fld[3:0]}];
							default: e = {fld[6], fld[5:0]};
						endcase
						if (!e[6])
							exp_next[x % 512] = e;
						x++;
					end
				end
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------
	task automatic fail_run();
		error_count++;
		$display("tests failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_pixel(input int col, input raster_pkg::color_t got,
		input raster_pkg::color_t exp, input logic got_op, input logic exp_op);
		if (got_op !== exp_op)
		begin
			$display("[ERROR] pixel_opaque line %0d col %0d: got %h expected %h",
				tb_line, col, got_op, exp_op);
			fail_run();
		end
		else if (exp_op && got !== exp)
		begin
			$display("[ERROR] pixel line %0d col %0d: got %h expected %h",
				tb_line, col, got, exp);
			fail_run();
		end
	endtask

	task automatic check_word(input fetch_pkg::mem_word_t got, input fetch_pkg::mem_word_t exp,
		input fetch_pkg::mem_addr_t addr);
		if (got !== exp)
		begin
			$display("[ERROR] mem_data host read %h: got %h expected %h", addr, got, exp);
			fail_run();
		end
	endtask

	task automatic check_busy(input logic got, input logic exp, input string when);
		if (got !== exp)
		begin
			$display("[ERROR] render_busy %s: got %h expected %h", when, got, exp);
			fail_run();
		end
	endtask

	task automatic host_read(input fetch_pkg::mem_addr_t addr);
		int waited;
		waited    = 0;
		host_addr = addr;
		host_req  = 1'b1;	// held until the strobe
		@(negedge clk);
		while (!host_strobe)
		begin
			waited++;
			if (waited > HOST_LIMIT)
			begin
				$display("host read of %h got no strobe within %0d cycles", addr, HOST_LIMIT);
				fail_run();
			end
			@(negedge clk);
		end
		check_word(mem_data, fill_word(addr, frame_salt[cur_frame]), addr);
		host_req = 1'b0;
	endtask

	task automatic host_traffic(input int count);
		repeat (20) @(negedge clk);	// engine is walking by now
		for (int i = 0; i < count; i++)
		begin
			host_read(21'((tb_line * 37 + i * 113 + 'h150) & 'hfff));
			repeat (7) @(negedge clk);
		end
	endtask

	// pixel k lands on the 4th edge of step k after line_start falls
	task automatic readout(input logic check_pix);
		for (int k = 0; k < LINE_PIXELS - 1; k++)
		begin
			repeat (raster_pkg::CLOCKS_PER_PIXEL) @(posedge clk);
			@(negedge clk);
			if (check_pix)
				check_pixel(k, pixel, exp_cur[k][5:0], pixel_opaque, ~exp_cur[k][6]);
		end
	endtask

	task automatic run_line(input logic pre, input logic check_pix, input int host_n);
		check_busy(render_busy, 1'b0, "before line_start");
		if (pre)
			load_frame(cur_frame);	// engine idle here
		tb_line = pre ? 9'd0 : tb_line + 9'd1;
		exp_cur = exp_next;
		render_ref(tb_line);
		line_start = 1'b1;
		pre_vline  = pre;
		@(negedge clk);
		line_start = 1'b0;
		pre_vline  = 1'b0;
		check_busy(render_busy, 1'b1, "after line_start");
		fork
			readout(check_pix);
			host_traffic(host_n);
		join
		repeat (LINE_CLOCKS - 1 - raster_pkg::CLOCKS_PER_PIXEL * (LINE_PIXELS - 1))
			@(negedge clk);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		line_start = 1'b1;	// reset
		pre_vline  = 1'b1;
		host_req   = 1'b0;
		host_addr  = '0;
		fill_table();
		for (int i = 0; i < 256; i++)
			i_mem.pal[i] = {i[1:0] == 2'b00, i[7:2] ^ {i[1:0], 4'b0000}};
		cur_frame = 0;
		load_frame(0);
		for (int k = 0; k < 512; k++)
			exp_next[k] = 7'h40;
		tb_line = '0;
		repeat (3) @(negedge clk);
		line_start = 1'b0;
		pre_vline  = 1'b0;
		repeat (LINE_CLOCKS - 3) @(negedge clk);	// buffers wiped by read-out
		lines_run = 0;
		for (int f = 0; f < FRAMES; f++)
		begin
			cur_frame = f;
			for (int l = 0; l < frame_lines[f]; l++)
			begin
				run_line(l == 0, lines_run >= 1, frame_hosts[f]);	// first one shows junk
				lines_run++;
			end
		end
		check_busy(render_busy, 1'b0, "after last line");
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== sprite_unit.f ====
logic/raster_pkg.sv
logic/fetch_pkg.sv
logic/line_buffer_ram.sv
logic/line_store.sv
logic/sprite_engine.sv
logic/mem_arbiter.sv
logic/sprite_unit.sv
dv/sprite_mem_model.sv
dv/sprite_unit_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with verilator and run sprite_unit_tb"
	@echo "make clean  remove build output and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module sprite_unit_tb \
		-f sprite_unit.f -o sim_sprite_unit
	./obj_dir/sim_sprite_unit | tee sim.log
	@if grep -q "tests failed" sim.log; then echo "FAIL"; exit 1; fi
	@if grep -q "all tests passed" sim.log; then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
